// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_dds_lab -f verilog.f
	./obj_dir/Vtb_dds_lab | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== hdl/dds_lab_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dds_lab_top
   import dds_pkg::*;
#(
   parameter phase_t      PHASE_INC = 32'd258,
   parameter int unsigned TICK_DIV  = 25
)
(
   input  wire logic       CLK_25MHZ,
   input  wire logic       reset_from_key,
   input  wire wave_sel_e  wave_select,
   input  wire mod_sel_e   mod_select,
   input  wire key_event_t key_event,
   output sample_t         signal_sample,
   output sample_t         modulated_sample,
   output key_word_t       held_keys
);

   wave_set_t waves;
   logic      lfsr_bit;

   //////////////////////////////////////////////////////////////////////
   // signal generation
   //////////////////////////////////////////////////////////////////////

   dds_waveform_gen #(
      .PHASE_INC (PHASE_INC)
   ) u_wavegen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .waves          (waves)
   );

   lfsr_bit_source #(
      .TICK_DIV (TICK_DIV)
   ) u_lfsr (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_bit       (lfsr_bit)
   );

   signal_modulator u_modulator (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .waves            (waves),
      .lfsr_bit         (lfsr_bit),
      .wave_select      (wave_select),
      .mod_select       (mod_select),
      .signal_sample    (signal_sample),      // phase of cycle n at n+2
      .modulated_sample (modulated_sample)
   );

   // keyboard flags
   key_hold_tracker u_keys (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event      (key_event),
      .held_keys      (held_keys)
   );

endmodule

`default_nettype wire

// ==== hdl/dds_pkg.sv ====
`default_nettype none

package dds_pkg;

   //////////////////////////////////////////////////////////////////////
   // sample and phase types
   //////////////////////////////////////////////////////////////////////

   typedef logic signed [11:0] sample_t;      // two's complement sample
   typedef logic [31:0] phase_t;              // accumulator phase

   localparam sample_t SAMPLE_MAX = 12'sh7FF;  // +2047
   localparam sample_t SAMPLE_MIN = 12'sh800;  // -2048

   typedef struct packed {
      sample_t sine;
      sample_t cosine;
      sample_t square;
      sample_t sawtooth;
   } wave_set_t;

   typedef enum logic [1:0] {
      WAVE_SINE     = 2'd0,
      WAVE_COSINE   = 2'd1,
      WAVE_SQUARE   = 2'd2,
      WAVE_SAWTOOTH = 2'd3
   } wave_sel_e;

   typedef enum logic [1:0] {
      MOD_ASK          = 2'd0,
      MOD_BPSK         = 2'd1,
      MOD_LFSR_DISPLAY = 2'd2,
      MOD_OFF          = 2'd3
   } mod_sel_e;

   //////////////////////////////////////////////////////////////////////
   // keyboard events
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic       ready;                      // one-cycle strobe
      logic [7:0] code;                       // make or break code
   } key_event_t;

   typedef logic [31:0] key_word_t;

   localparam int NUM_KEYS = 17;

   // 1..8, F1, F2, N, M, SPACE, LEFT, RIGHT, UP, DOWN
   localparam logic [7:0] KEY_MAKE_CODES [NUM_KEYS] = '{
      8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08,
      8'h09, 8'h0A, 8'h0B, 8'h0C, 8'h0D, 8'h0E, 8'h0F, 8'h10, 8'h11
   };

   localparam string SINE_TABLE_FILE = "sine_table.hex";
   localparam int    SINE_ADDR_BITS  = 6;

endpackage

`default_nettype wire

// ==== hdl/dds_waveform_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module dds_waveform_gen
   import dds_pkg::*;
#(
   parameter phase_t PHASE_INC = 32'd258
)
(
   input  wire logic CLK_25MHZ,
   input  wire logic reset_from_key,
   output wave_set_t waves
);

   localparam int TABLE_DEPTH = 2**SINE_ADDR_BITS;
   localparam logic [SINE_ADDR_BITS-1:0] QUARTER_TURN = SINE_ADDR_BITS'(TABLE_DEPTH / 4);

   phase_t                    phase;
   sample_t                   sine_rom [TABLE_DEPTH];
   logic [SINE_ADDR_BITS-1:0] sin_addr;
   logic [SINE_ADDR_BITS-1:0] cos_addr;

   // one full period for sine and cosine
   initial
   begin
      $readmemh(SINE_TABLE_FILE, sine_rom);
   end

   //////////////////////////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + PHASE_INC;                  // wraps at 2^32
      end
   end

   assign sin_addr = phase[$bits(phase_t)-1 -: SINE_ADDR_BITS];
   assign cos_addr = sin_addr + QUARTER_TURN;        // 90 degrees ahead with wrap

   //////////////////////////////////////////////////////////////////////
   // registered sample outputs
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         waves <= '0;
      end
      else
      begin
         waves.sine     <= sine_rom[sin_addr];
         waves.cosine   <= sine_rom[cos_addr];
         waves.square   <= phase[$bits(phase_t)-1] ? SAMPLE_MIN : SAMPLE_MAX;
         waves.sawtooth <= $signed(phase[$bits(phase_t)-1 -: $bits(sample_t)]);
      end
   end

endmodule

`default_nettype wire

// ==== hdl/key_hold_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_hold_tracker
   import dds_pkg::*;
(
   input  wire logic       CLK_25MHZ,
   input  wire logic       reset_from_key,
   input  wire key_event_t key_event,
   output key_word_t       held_keys
);

   localparam logic [7:0] BREAK_FLAG = 8'h80;       // break = make with bit 7 set
   localparam int         PAD_BITS   = $bits(key_word_t) - NUM_KEYS;

   logic [NUM_KEYS-1:0] held;
   logic [NUM_KEYS-1:0] make_hit;
   logic [NUM_KEYS-1:0] break_hit;

   //////////////////////////////////////////////////////////////////////
   // event decode
   //////////////////////////////////////////////////////////////////////

   // key index i lands on bit NUM_KEYS-1-i, so key "1" is the top flag
   always_comb
   begin
      make_hit  = '0;
      break_hit = '0;
      for (int i = 0; i < NUM_KEYS; i++)
      begin
         make_hit[NUM_KEYS-1-i]  = key_event.ready &&
                                   (key_event.code == KEY_MAKE_CODES[i]);
         break_hit[NUM_KEYS-1-i] = key_event.ready &&
                                   (key_event.code == (KEY_MAKE_CODES[i] | BREAK_FLAG));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // held flags
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held <= '0;
      end
      else
      begin
         held <= (held | make_hit) & ~break_hit;     // unknown codes leave flags alone
      end
   end

   assign held_keys = {{PAD_BITS{1'b0}}, held};

endmodule

`default_nettype wire

// ==== hdl/lfsr_bit_source.sv ====
`timescale 1ns/10ps
`default_nettype none

module lfsr_bit_source
#(
   parameter int unsigned TICK_DIV = 25
)
(
   input  wire logic CLK_25MHZ,
   input  wire logic reset_from_key,
   output logic      lfsr_bit
);

   localparam int         CNT_W     = $clog2(TICK_DIV);
   localparam logic [4:0] LFSR_SEED = 5'b00001;
   localparam logic [4:0] LFSR_TAPS = 5'b10100;     // x^5 + x^3 + 1

   logic [CNT_W-1:0] div_cnt;
   logic             tick;
   logic [4:0]       lfsr;

   assign tick = (div_cnt == CNT_W'(TICK_DIV - 1));  // last count of the period

   //////////////////////////////////////////////////////////////////////
   // tick divider
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         div_cnt <= '0;
      else if (tick)
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // Galois form where bit 0 shifts out and folds the taps back in
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr <= LFSR_SEED;
      else if (tick)
         lfsr <= {1'b0, lfsr[4:1]} ^ (lfsr[0] ? LFSR_TAPS : 5'b00000);
   end

   assign lfsr_bit = lfsr[0];

endmodule

`default_nettype wire

// ==== hdl/signal_modulator.sv ====
`timescale 1ns/10ps
`default_nettype none

module signal_modulator
   import dds_pkg::*;
(
   input  wire logic      CLK_25MHZ,
   input  wire logic      reset_from_key,
   input  wire wave_set_t waves,
   input  wire logic      lfsr_bit,
   input  wire wave_sel_e wave_select,
   input  wire mod_sel_e  mod_select,
   output sample_t        signal_sample,
   output sample_t        modulated_sample
);

   sample_t sel_wave;
   sample_t mod_value;

   //////////////////////////////////////////////////////////////////////
   // waveform select
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (wave_select)
         WAVE_SINE:   sel_wave = waves.sine;
         WAVE_COSINE: sel_wave = waves.cosine;
         WAVE_SQUARE: sel_wave = waves.square;
         default:     sel_wave = waves.sawtooth;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // modulation
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (mod_select)
         MOD_ASK:          mod_value = lfsr_bit ? sel_wave : '0;      // on/off keying
         MOD_BPSK:         mod_value = lfsr_bit ? -sel_wave : sel_wave; // -2048 maps to itself
         MOD_LFSR_DISPLAY: mod_value = lfsr_bit ? SAMPLE_MIN : '0;
         default:          mod_value = '0;                            // output off
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         signal_sample    <= '0;
         modulated_sample <= '0;
      end
      else
      begin
         signal_sample    <= sel_wave;
         modulated_sample <= mod_value;
      end
   end

endmodule

`default_nettype wire

// ==== sine_table.hex ====
// one signed 12-bit sine sample per line, addresses 0 to 63, one full period
000
0C9
18F
252
30F
3C5
471
513
5A7
62E
6A6
70D
763
7A7
7D8
7F5
7FF
7F5
7D8
7A7
763
70D
6A6
62E
5A7
513
471
3C5
30F
252
18F
0C9
000
F37
E71
DAE
CF1
C3B
B8F
AED
A59
9D2
95A
8F3
89D
859
828
80B
801
80B
828
859
89D
8F3
95A
9D2
A59
AED
B8F
C3B
CF1
DAE
E71
F37

// ==== testbench/tb_dds_lab.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dds_lab
   import dds_pkg::*;
();

   localparam phase_t      PHASE_INC   = 32'd258;
   localparam int unsigned TICK_DIV    = 25;
   localparam int          MAIN_CYCLES = 2000;
   localparam int          SEQ_TICKS   = 62;               // two full LFSR periods
   localparam int          SEQ_LIMIT   = (SEQ_TICKS + 2) * TICK_DIV;

   logic       CLK_25MHZ;
   logic       reset_from_key;
   wave_sel_e  wave_select;
   mod_sel_e   mod_select;
   key_event_t key_event;
   sample_t    signal_sample;
   sample_t    modulated_sample;
   key_word_t  held_keys;

   // reference model state
   sample_t     sine_model [64];
   phase_t      m_phase;
   phase_t      m_phase_d;                              // phase one edge back
   int unsigned m_div;
   logic [4:0]  m_lfsr;
   key_word_t   m_keys;
   int          m_edges;                                // edges since reset release
   wave_sel_e   cur_wave;                               // inputs seen by the next edge
   mod_sel_e    cur_mod;
   key_event_t  cur_event;
   logic [31:0] rng_state;
   int          mismatch_count;
   int          other_count;
   logic        seq_bits [$];

   dds_lab_top UUT (
      .CLK_25MHZ        (CLK_25MHZ),
      .reset_from_key   (reset_from_key),
      .wave_select      (wave_select),
      .mod_select       (mod_select),
      .key_event        (key_event),
      .signal_sample    (signal_sample),
      .modulated_sample (modulated_sample),
      .held_keys        (held_keys)
   );

   always
   begin
      #20 CLK_25MHZ = ~CLK_25MHZ;                       // 40 ns period
   end

   //////////////////////////////////////////////////////////////////////
   // random source and expected-value rules
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] value;
      int          i;
      value = '0;
      for (i = 0; i < n; i++)
      begin
         rng_state = rng_state[0] ? ((rng_state >> 1) ^ 32'h8020_0003) : (rng_state >> 1);
         value     = {value[30:0], rng_state[0]};
      end
      return value;
   endfunction

   function automatic logic [7:0] make_code_of(input int idx);
      return 8'(idx + 1);                                // 8'h01 for key "1" up to 8'h11 for DOWN
   endfunction

   function automatic key_event_t random_key_event();
      key_event_t  ev;
      logic [1:0]  kind;
      int unsigned key_idx;
      kind     = 2'(rand_bits(2));
      key_idx  = rand_bits(5) % NUM_KEYS;
      ev.ready = (rand_bits(1) != 0);
      if (kind == 2'd3)
         ev.code = 8'(rand_bits(8));                     // mostly unknown codes
      else if (kind == 2'd2)
         ev.code = make_code_of(key_idx) | 8'h80;        // break
      else
         ev.code = make_code_of(key_idx);                // make
      return ev;
   endfunction

   function automatic sample_t wave_of(input phase_t p, input wave_sel_e sel);
      logic [5:0] addr;
      logic [5:0] cos_addr;
      sample_t    result;
      addr     = p[31:26];
      cos_addr = addr + 6'd16;                           // quarter turn with wrap at 64
      case (sel)
         WAVE_SINE:   result = sine_model[addr];
         WAVE_COSINE: result = sine_model[cos_addr];
         WAVE_SQUARE: result = p[31] ? sample_t'(-2048) : sample_t'(2047);
         default:     result = sample_t'(p[31:20]);
      endcase
      return result;
   endfunction

   function automatic sample_t mod_of(input sample_t v, input mod_sel_e sel, input logic b);
      sample_t result;
      case (sel)
         MOD_ASK:          result = b ? v : sample_t'(0);
         MOD_BPSK:         result = b ? sample_t'(~v + 12'd1) : v;
         MOD_LFSR_DISPLAY: result = b ? sample_t'(-2048) : sample_t'(0);
         default:          result = sample_t'(0);
      endcase
      return result;
   endfunction

   function automatic logic [4:0] galois5_step(input logic [4:0] s);
      logic [4:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 5'b10100;                               // x^5 + x^3 + 1
      return n;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // compare tasks and one clock step
   //////////////////////////////////////////////////////////////////////

   task automatic check_sample(input sample_t expected, input sample_t actual, input string label);
      if (actual !== expected)
      begin
         $display("Fail at %0d ns: %s expected %0d, got %0d", $time, label, expected, actual);
         mismatch_count++;
      end
   endtask

   task automatic check_keys(input key_word_t expected, input key_word_t actual);
      if (actual !== expected)
      begin
         $display("Fail at %0d ns: held_keys expected %h, got %h", $time, expected, actual);
         mismatch_count++;
      end
   endtask

   task automatic step_cycle(input wave_sel_e ws, input mod_sel_e ms, input key_event_t ev);
      sample_t exp_wave;
      sample_t exp_mod;
      int      i;
      @(posedge CLK_25MHZ);
      #2;
      m_edges++;
      exp_wave = (m_edges >= 2) ? wave_of(m_phase_d, cur_wave) : sample_t'(0);
      exp_mod  = mod_of(exp_wave, cur_mod, m_lfsr[0]);
      if (cur_event.ready)
      begin
         for (i = 0; i < NUM_KEYS; i++)
         begin
            if (cur_event.code == make_code_of(i))
               m_keys[NUM_KEYS-1-i] = 1'b1;
            else if (cur_event.code == (make_code_of(i) | 8'h80))
               m_keys[NUM_KEYS-1-i] = 1'b0;
         end
      end
      check_sample(exp_wave, signal_sample, "signal_sample");
      check_sample(exp_mod, modulated_sample, "modulated_sample");
      check_keys(m_keys, held_keys);
      m_phase_d = m_phase;
      m_phase   = m_phase + PHASE_INC;
      if (m_div == TICK_DIV - 1)
      begin
         m_div  = 0;
         m_lfsr = galois5_step(m_lfsr);                  // one step per tick
      end
      else
      begin
         m_div++;
      end
      wave_select = ws;
      mod_select  = ms;
      key_event   = ev;
      cur_wave    = ws;
      cur_mod     = ms;
      cur_event   = ev;
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      wave_sel_e next_wave;
      mod_sel_e  next_mod;
      int        hold;
      int        cyc;
      int        ones;
      int        i;
      CLK_25MHZ      = 1'b0;
      reset_from_key = 1'b1;
      wave_select    = WAVE_SINE;
      mod_select     = MOD_OFF;
      key_event      = '0;
      cur_wave       = WAVE_SINE;
      cur_mod        = MOD_OFF;
      cur_event      = '0;
      rng_state      = 32'hd1;
      mismatch_count = 0;
      other_count    = 0;
      m_phase        = '0;
      m_phase_d      = '0;
      m_div          = 0;
      m_lfsr         = 5'b00001;
      m_keys         = '0;
      m_edges        = 0;
      next_wave      = WAVE_SINE;
      next_mod       = MOD_OFF;
      $readmemh("sine_table.hex", sine_model);

      repeat (2) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;
      check_sample(sample_t'(0), signal_sample, "signal_sample after reset");
      check_sample(sample_t'(0), modulated_sample, "modulated_sample after reset");
      check_keys('0, held_keys);

      // random selectors held a few cycles at a time
      hold = 0;
      for (cyc = 0; cyc < MAIN_CYCLES; cyc++)
      begin
         if (hold == 0)
         begin
            next_wave = wave_sel_e'(2'(rand_bits(2)));
            next_mod  = mod_sel_e'(2'(rand_bits(2)));
            hold      = 1 + int'(rand_bits(2));
         end
         hold--;
         step_cycle(next_wave, next_mod, random_key_event());
      end

      // LFSR bit through the display mode with one sample per tick
      seq_bits.delete();
      cyc = 0;
      while (seq_bits.size() < SEQ_TICKS && cyc < SEQ_LIMIT)
      begin
         step_cycle(wave_sel_e'(2'(rand_bits(2))), MOD_LFSR_DISPLAY, random_key_event());
         if (cyc > 0 && m_div == 0)
            seq_bits.push_back(modulated_sample == SAMPLE_MIN);
         cyc++;
      end
      if (seq_bits.size() < SEQ_TICKS)
      begin
         $display("Timeout: only %0d LFSR ticks were seen in display mode", seq_bits.size());
         other_count++;
      end
      else
      begin
         ones = 0;
         for (i = 0; i < 31; i++)
         begin
            if (seq_bits[i] !== seq_bits[i+31])
            begin
               $display("The LFSR bit sequence does not repeat after 31 ticks at tick %0d", i);
               other_count++;
            end
            if (seq_bits[i])
               ones++;
         end
         if (ones != 16)
         begin
            $display("The LFSR bit shows %0d ones in 31 ticks instead of 16", ones);
            other_count++;
         end
      end

      $display("errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/dds_pkg.sv
hdl/dds_waveform_gen.sv
hdl/lfsr_bit_source.sv
hdl/signal_modulator.sv
hdl/key_hold_tracker.sv
hdl/dds_lab_top.sv
testbench/tb_dds_lab.sv
